// File: Bender.yml
package:
  name: fpu

sources:
  - logic/fpuPkg.sv
  - logic/fpuOperandIntf.sv
  - logic/fpuRawIntf.sv
  - logic/fpuOperandStage.sv
  - logic/fpuComputeStage.sv
  - logic/fpuNormalizeStage.sv
  - logic/fpuRoundStage.sv
  - logic/fpuTop.sv
  - target: test
    files:
      - test/fpuTb.sv

// File: all.f
logic/fpuPkg.sv
logic/fpuOperandIntf.sv
logic/fpuRawIntf.sv
logic/fpuOperandStage.sv
logic/fpuComputeStage.sv
logic/fpuNormalizeStage.sv
logic/fpuRoundStage.sv
logic/fpuTop.sv
test/fpuTb.sv

// File: logic/fpuComputeStage.sv
`timescale 1ns/100ps

module fpuComputeStage (
  input  logic       clk,
  input  logic       rstN,
  fpuOperandIntf.dst opIn,
  fpuRawIntf.src     rawOut
);
  import fpuPkg::*;

  logic        loadEn;
  logic        aBigger;
  logic        bigSign;
  workExpT     bigExp;
  workExpT     expDiff;
  logic [26:0] bigExt;
  logic [26:0] smallExt;
  logic [26:0] smallAl;
  logic [26:0] lostBits;
  logic        sticky;
  logic        effSub;
  logic [27:0] sum;
  logic [47:0] product;
  logic        nextSign;
  workExpT     nextExp;
  rawSigT      nextSig;
  specT        nextSpec;
  logic        nextSpecSign;

  assign loadEn     = !rawOut.valid || !rawOut.stall;
  assign opIn.stall = rawOut.valid && rawOut.stall;

  // Order by magnitude
  assign aBigger  = {opIn.expA, opIn.sigA} >= {opIn.expB, opIn.sigB};
  assign bigSign  = aBigger ? opIn.signA : opIn.signB;
  assign bigExp   = aBigger ? opIn.expA : opIn.expB;
  assign expDiff  = aBigger ? (opIn.expA - opIn.expB) : (opIn.expB - opIn.expA);
  // Three extra bits for guard, round and sticky
  assign bigExt   = aBigger ? {opIn.sigA, 3'b000} : {opIn.sigB, 3'b000};
  assign smallExt = aBigger ? {opIn.sigB, 3'b000} : {opIn.sigA, 3'b000};
  assign effSub   = opIn.signA ^ opIn.signB;

  // Alignment shift with sticky
  always_comb begin
    if (expDiff > 10'sd26) begin
      smallAl  = '0;
      lostBits = smallExt;
    end else begin
      {smallAl, lostBits} = {smallExt, 27'd0} >> expDiff[4:0];
    end
    sticky = |lostBits;
    smallAl[0] = smallAl[0] | sticky;
  end

  // Larger minus smaller never goes negative
  assign sum = effSub ? ({1'b0, bigExt} - {1'b0, smallAl})
                      : ({1'b0, bigExt} + {1'b0, smallAl});

  assign product = opIn.sigA * opIn.sigB;

  always_comb begin
    nextSpec     = opIn.spec;
    nextSpecSign = opIn.specSign;
    if (opIn.op == OpMul) begin
      nextSign = opIn.signA ^ opIn.signB;
      nextExp  = opIn.expA + opIn.expB - ExpBias;
      nextSig  = {product, 2'b00};
    end else begin
      nextSign = bigSign;
      nextExp  = bigExp;
      // Sum at the top, carry lands on bit 49
      nextSig  = {sum, 22'd0};
      // Exact cancellation gives +0
      if (effSub && sum == '0 && opIn.spec == SpecNone) begin
        nextSpec     = SpecZero;
        nextSpecSign = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rawOut.valid <= 1'b0;
    end else if (loadEn) begin
      rawOut.valid <= opIn.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (loadEn) begin
      rawOut.sign     <= nextSign;
      rawOut.exp      <= nextExp;
      rawOut.sig      <= nextSig;
      rawOut.spec     <= nextSpec;
      rawOut.specSign <= nextSpecSign;
    end
  end

endmodule

// File: logic/fpuNormalizeStage.sv
`timescale 1ns/100ps

module fpuNormalizeStage (
  input  logic   clk,
  input  logic   rstN,
  fpuRawIntf.dst rawIn,
  fpuRawIntf.src rawOut
);
  import fpuPkg::*;

  logic       loadEn;
  logic [5:0] leadPos;
  logic [5:0] shiftAmt;
  logic       sigZero;
  logic       lostBit;
  rawSigT     normSig;
  workExpT    normExp;
  rawSigT     nextSig;
  specT       nextSpec;
  logic       nextSpecSign;

  assign loadEn      = !rawOut.valid || !rawOut.stall;
  assign rawIn.stall = rawOut.valid && rawOut.stall;

  assign sigZero = (rawIn.sig == '0);

  // Priority search for the leading one below the carry bit
  always_comb begin
    leadPos = 6'd0;
    for (int i = 0; i < 49; i++) begin
      if (rawIn.sig[i]) begin
        leadPos = 6'(i);
      end
    end
  end

  assign shiftAmt = 6'd48 - leadPos;

  always_comb begin
    if (rawIn.sig[49]) begin
      // Carry out, one step right
      normSig = rawIn.sig >> 1;
      normExp = rawIn.exp + 10'sd1;
      lostBit = rawIn.sig[0];
    end else begin
      normSig = rawIn.sig << shiftAmt;
      normExp = rawIn.exp - workExpT'({4'b0000, shiftAmt});
      lostBit = 1'b0;
    end
  end

  // Keep fraction, guard and round, fold the rest into bit 0
  assign nextSig = {normSig[49:23], 22'd0, (|normSig[22:0]) | lostBit};

  always_comb begin
    nextSpec     = rawIn.spec;
    nextSpecSign = rawIn.specSign;
    // Zero or below the normal range
    if (rawIn.spec == SpecNone && (sigZero || normExp <= 10'sd0)) begin
      nextSpec     = SpecZero;
      nextSpecSign = rawIn.sign;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rawOut.valid <= 1'b0;
    end else if (loadEn) begin
      rawOut.valid <= rawIn.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (loadEn) begin
      rawOut.sign     <= rawIn.sign;
      rawOut.exp      <= normExp;
      rawOut.sig      <= nextSig;
      rawOut.spec     <= nextSpec;
      rawOut.specSign <= nextSpecSign;
    end
  end

endmodule

// File: logic/fpuOperandIntf.sv
`timescale 1ns/100ps

interface fpuOperandIntf;
  import fpuPkg::*;

  // Forward valid, backward stall
  logic valid;
  logic stall;

  // Operation, subtract already folded into signB
  opT op;

  // Unpacked operands
  logic    signA;
  logic    signB;
  workExpT expA;
  workExpT expB;
  sigT     sigA;
  sigT     sigB;

  // Special-case decision
  specT spec;
  logic specSign;

  modport src (output valid, op, signA, signB, expA, expB, sigA, sigB, spec, specSign,
               input stall);
  modport dst (input valid, op, signA, signB, expA, expB, sigA, sigB, spec, specSign,
               output stall);

endinterface

// File: logic/fpuOperandStage.sv
`timescale 1ns/100ps

module fpuOperandStage (
  input  logic           clk,
  input  logic           rstN,
  input  logic           inReq,
  input  fpuPkg::opT     inOp,
  input  fpuPkg::fpWordT inA,
  input  fpuPkg::fpWordT inB,
  output logic           inAck,
  fpuOperandIntf.src     opOut
);
  import fpuPkg::*;

  typedef enum logic {idle, waitReqLow} inStateT;

  inStateT state;
  logic    regFree;
  logic    capture;
  logic    zeroA, zeroB, infA, infB, nanA, nanB;
  logic    effSignB;
  specT    nextSpec;
  logic    nextSpecSign;

  // Register free when empty or its item moves on
  assign regFree = !opOut.valid || !opOut.stall;
  assign capture = (state == idle) && inReq && regFree;
  assign inAck   = (state == waitReqLow);

  // Classify, denormals count as zero
  assign zeroA = (inA[30:23] == 8'h00);
  assign zeroB = (inB[30:23] == 8'h00);
  assign infA  = (inA[30:23] == 8'hFF) && (inA[22:0] == '0);
  assign infB  = (inB[30:23] == 8'hFF) && (inB[22:0] == '0);
  assign nanA  = (inA[30:23] == 8'hFF) && (inA[22:0] != '0);
  assign nanB  = (inB[30:23] == 8'hFF) && (inB[22:0] != '0);

  // Subtract becomes add of negated B
  assign effSignB = inB[31] ^ (inOp == OpSub);

  always_comb begin
    nextSpec     = SpecNone;
    nextSpecSign = 1'b0;
    if (inOp == OpMul) begin
      if (nanA || nanB || (infA && zeroB) || (zeroA && infB)) begin
        nextSpec = SpecNan;
      end else if (infA || infB) begin
        nextSpec     = SpecInf;
        nextSpecSign = inA[31] ^ inB[31];
      end
    end else if (inOp == OpAdd || inOp == OpSub) begin
      if (nanA || nanB || (infA && infB && (inA[31] != effSignB))) begin
        nextSpec = SpecNan;
      end else if (infA || infB) begin
        nextSpec = SpecInf;
        // Infinity keeps its own sign
        nextSpecSign = infA ? inA[31] : effSignB;
      end
    end else begin
      // Reserved code
      nextSpec = SpecNan;
    end
  end

  // Input handshake and valid
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= idle;
      opOut.valid <= 1'b0;
    end else begin
      if (regFree) begin
        opOut.valid <= capture;
      end
      if (capture) begin
        state <= waitReqLow;
      end else if (state == waitReqLow && !inReq) begin
        state <= idle;
      end
    end
  end

  // Unpacked operand register
  always_ff @(posedge clk) begin
    if (capture) begin
      opOut.op       <= inOp;
      opOut.signA    <= inA[31];
      opOut.signB    <= effSignB;
      opOut.expA     <= workExpT'({2'b00, inA[30:23]});
      opOut.expB     <= workExpT'({2'b00, inB[30:23]});
      // Hidden bit restored, flushed operands get zero significand
      opOut.sigA     <= zeroA ? '0 : {1'b1, inA[22:0]};
      opOut.sigB     <= zeroB ? '0 : {1'b1, inB[22:0]};
      opOut.spec     <= nextSpec;
      opOut.specSign <= nextSpecSign;
    end
  end

endmodule

// File: logic/fpuPkg.sv
package fpuPkg;

  // Packed IEEE single
  typedef logic [31:0] fpWordT;

  // Operation code
  typedef logic [1:0] opT;

  // Special result class
  typedef logic [1:0] specT;

  // Working exponent, signed so underflow shows as negative
  typedef logic signed [9:0] workExpT;

  // Significand with hidden bit
  typedef logic [23:0] sigT;

  // Working significand
  // Bit 49 is the carry position, bit 48 the hidden-bit position
  typedef logic [49:0] rawSigT;

  // Operation codes, code 3 is reserved
  localparam opT OpAdd = 2'd0;
  localparam opT OpSub = 2'd1;
  localparam opT OpMul = 2'd2;

  // Special result classes
  localparam specT SpecNone = 2'd0;
  localparam specT SpecNan  = 2'd1;
  localparam specT SpecInf  = 2'd2;
  localparam specT SpecZero = 2'd3;

  // Exponent constants
  localparam workExpT ExpBias = 10'sd127;
  localparam workExpT ExpMax  = 10'sd255;

  // Canonical NaN
  localparam fpWordT CanonNan = 32'hFFFF_FFFF;

endpackage

// File: logic/fpuRawIntf.sv
`timescale 1ns/100ps

interface fpuRawIntf;
  import fpuPkg::*;

  // Forward valid, backward stall
  logic valid;
  logic stall;

  // Unrounded value
  logic    sign;
  workExpT exp;
  rawSigT  sig;

  // Special-case decision carried along
  specT spec;
  logic specSign;

  // Producer side
  modport src (output valid, sign, exp, sig, spec, specSign,
               input stall);

  // Consumer side
  modport dst (input valid, sign, exp, sig, spec, specSign,
               output stall);

endinterface

// File: logic/fpuRoundStage.sv
`timescale 1ns/100ps

module fpuRoundStage (
  input  logic           clk,
  input  logic           rstN,
  fpuRawIntf.dst         rawIn,
  output logic           outReq,
  output fpuPkg::fpWordT outResult,
  input  logic           outAck
);
  import fpuPkg::*;

  typedef enum logic [1:0] {idle, reqHigh, waitAckLow} outStateT;

  outStateT    state;
  logic        guardBit;
  logic        roundBit;
  logic        stickyBit;
  logic        roundUp;
  logic [24:0] roundedMant;
  logic [22:0] fracOut;
  workExpT     expOut;
  fpWordT      packedWord;

  // Hidden bit at 48 and fraction from 47 down to 25
  assign guardBit  = rawIn.sig[24];
  assign roundBit  = rawIn.sig[23];
  assign stickyBit = |rawIn.sig[22:0];

  // Nearest even with ties to the even fraction
  assign roundUp = guardBit && (roundBit || stickyBit || rawIn.sig[25]);

  assign roundedMant = {1'b0, rawIn.sig[48:25]} + {24'd0, roundUp};

  always_comb begin
    if (roundedMant[24]) begin
      // Renormalize after a rounding carry
      fracOut = roundedMant[23:1];
      expOut  = rawIn.exp + 10'sd1;
    end else begin
      fracOut = roundedMant[22:0];
      expOut  = rawIn.exp;
    end
  end

  always_comb begin
    case (rawIn.spec)
      SpecNan:  packedWord = CanonNan;
      SpecInf:  packedWord = {rawIn.specSign, 8'hFF, 23'd0};
      SpecZero: packedWord = {rawIn.specSign, 31'd0};
      default: begin
        if (expOut >= ExpMax) begin
          // Overflow to signed infinity
          packedWord = {rawIn.sign, 8'hFF, 23'd0};
        end else begin
          packedWord = {rawIn.sign, expOut[7:0], fracOut};
        end
      end
    endcase
  end

  // Busy until the sink has dropped outAck
  assign rawIn.stall = (state != idle);
  assign outReq      = (state == reqHigh);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= idle;
    end else begin
      case (state)
        idle:       if (rawIn.valid) state <= reqHigh;
        reqHigh:    if (outAck) state <= waitAckLow;
        waitAckLow: if (!outAck) state <= idle;
        default:    state <= idle;
      endcase
    end
  end

  // Result held stable while outReq is up
  always_ff @(posedge clk) begin
    if (state == idle && rawIn.valid) begin
      outResult <= packedWord;
    end
  end

endmodule

// File: logic/fpuTop.sv
`timescale 1ns/100ps

module fpuTop (
  input  logic           clk,
  input  logic           rstN,
  input  logic           inReq,
  input  fpuPkg::opT     inOp,
  input  fpuPkg::fpWordT inA,
  input  fpuPkg::fpWordT inB,
  output logic           inAck,
  output logic           outReq,
  output fpuPkg::fpWordT outResult,
  input  logic           outAck
);

  // Operand stage to compute stage
  fpuOperandIntf opLink ();

  // Compute to normalize, normalize to round
  fpuRawIntf rawMid ();
  fpuRawIntf rawLate ();

  // Input handshake, unpack and classify
  fpuOperandStage uOperand (
    .clk   (clk),
    .rstN  (rstN),
    .inReq (inReq),
    .inOp  (inOp),
    .inA   (inA),
    .inB   (inB),
    .inAck (inAck),
    .opOut (opLink)
  );

  // Align and add, or multiply
  fpuComputeStage uCompute (
    .clk    (clk),
    .rstN   (rstN),
    .opIn   (opLink),
    .rawOut (rawMid)
  );

  // Leading one to the hidden-bit position
  fpuNormalizeStage uNormalize (
    .clk    (clk),
    .rstN   (rstN),
    .rawIn  (rawMid),
    .rawOut (rawLate)
  );

  // Round, pack and output handshake
  fpuRoundStage uRound (
    .clk       (clk),
    .rstN      (rstN),
    .rawIn     (rawLate),
    .outReq    (outReq),
    .outResult (outResult),
    .outAck    (outAck)
  );

endmodule

// File: test/fpuStim.txt
# name op a b expected, all but the name in hex
# op 0 add, 1 subtract, 2 multiply, 3 reserved
addSimple 0 3F800000 40000000 40400000
subSimple 1 40400000 3F800000 40000000
addCarry 0 3FC00000 3FC00000 40400000
addMixedSign 0 BFC00000 3E800000 BFA00000
subDiffExp 1 41200000 3F000000 41180000
addFarOperand 0 3F800000 30800000 3F800000
subFarOperand 1 3F800000 30800000 3F800000
addRoundUp 0 3F800000 33C00000 3F800001
addRoundDown 0 3F800000 33000000 3F800000
addTieToEvenDown 0 3F800000 33800000 3F800000
addTieToEvenUp 0 3F800001 33800000 3F800002
subEqual 1 40400000 40400000 00000000
addOpposite 0 C0400000 40400000 00000000
subNearEqual 1 3F800001 3F800000 34000000
subAcrossBinade 1 3F800000 3F7FFFFF 33800000
mulSimple 2 40400000 40800000 41400000
mulCarry 2 3FC00000 3FC00000 40100000
mulNegative 2 C0000000 40400000 C0C00000
mulTie 2 3F800800 3F800800 3F801000
mulOverflow 2 71800000 71800000 7F800000
mulOverflowNeg 2 F1800000 71800000 FF800000
mulUnderflow 2 0D800000 0D800000 00000000
mulUnderflowNeg 2 8D800000 0D800000 80000000
nanA 0 7FC00000 3F800000 FFFFFFFF
nanB 2 3F800000 7F800001 FFFFFFFF
nanWithInf 1 7F800000 FFC00000 FFFFFFFF
infMinusInf 1 7F800000 7F800000 FFFFFFFF
infPlusNegInf 0 7F800000 FF800000 FFFFFFFF
infTimesZero 2 7F800000 00000000 FFFFFFFF
zeroTimesNegInf 2 00000000 FF800000 FFFFFFFF
negInfPlusOne 0 FF800000 3F800000 FF800000
oneMinusInf 1 3F800000 7F800000 FF800000
infTimesNeg 2 7F800000 C0000000 FF800000
denormPlusOne 0 00400000 3F800000 3F800000
denormTimesNeg 2 00400000 C0000000 80000000
denormNegSum 0 80400000 80000001 80000000
reservedOp 3 3F800000 3F800000 FFFFFFFF

// File: test/fpuTb.sv
`timescale 1ns/100ps

module fpuTb;
  import fpuPkg::*;

  localparam int ResetCycles     = 3;
  localparam int CyclesPerVector = 40;
  localparam int CycleMargin     = 20;
  localparam int MaxAckDelay     = 6;
  localparam int DrainCycles     = 8;

  logic   clk;
  logic   rstN;
  logic   inReq;
  opT     inOp;
  fpWordT inA;
  fpWordT inB;
  logic   inAck;
  logic   outReq;
  fpWordT outResult;
  logic   outAck;

  // Vectors in file order
  string  names[$];
  opT     ops[$];
  fpWordT aVals[$];
  fpWordT bVals[$];
  fpWordT expVals[$];

  int     valueErrors;
  int     protocolErrors;
  int     stimErrors;
  int     resultCount;
  int     cycleCount;
  int     cycleLimit;
  logic   firstReqSent;

  // Last sampled handshake values
  logic   prevInReq;
  logic   prevInAck;
  logic   prevOutReq;
  logic   prevOutAck;
  fpWordT prevResult;

  fpuTop fpuTop_inst (
    .clk       (clk),
    .rstN      (rstN),
    .inReq     (inReq),
    .inOp      (inOp),
    .inA       (inA),
    .inB       (inB),
    .inAck     (inAck),
    .outReq    (outReq),
    .outResult (outResult),
    .outAck    (outAck)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // Name, op, A, B, expected per line
  task automatic loadVectors();
    int     fd;
    int     fields;
    int     ch;
    logic   done;
    string  name;
    opT     op;
    fpWordT a;
    fpWordT b;
    fpWordT expected;
    done = 1'b0;
    fd = $fopen("test/fpuStim.txt", "r");
    if (fd == 0) begin
      stimErrors++;
      $display("Cannot open the stimulus file test/fpuStim.txt");
    end else begin
      while (!done) begin
        fields = $fscanf(fd, "%s", name);
        if (fields != 1) begin
          done = 1'b1;
        end else if (name[0] == "#") begin
          // Skip a comment line
          do begin
            ch = $fgetc(fd);
          end while (ch != 10 && ch != -1);
        end else begin
          fields = $fscanf(fd, " %h %h %h %h", op, a, b, expected);
          if (fields == 4) begin
            names.push_back(name);
            ops.push_back(op);
            aVals.push_back(a);
            bVals.push_back(b);
            expVals.push_back(expected);
          end else begin
            stimErrors++;
            $display("Stimulus line for %s is missing fields", name);
            done = 1'b1;
          end
        end
      end
      $fclose(fd);
    end
    if (names.size() == 0) begin
      stimErrors++;
      $display("No vectors found in the stimulus file");
    end
  endtask

  task automatic checkResult(input string testName, input fpWordT expected,
                             input fpWordT actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("error %s: expected %h, actual %h", testName, expected, actual);
    end
  endtask

  // Both waits return on the edge where the level is seen
  task automatic waitForInAck(input logic level);
    do begin
      @(posedge clk);
    end while (inAck !== level);
  endtask

  task automatic waitForOutReq(input logic level);
    do begin
      @(posedge clk);
    end while (outReq !== level);
  endtask

  // Source side of the input four-phase handshake
  task automatic driveInputs();
    @(posedge clk);
    for (int i = 0; i < names.size(); i++) begin
      inReq        <= 1'b1;
      inOp         <= ops[i];
      inA          <= aVals[i];
      inB          <= bVals[i];
      firstReqSent <= 1'b1;
      waitForInAck(1'b1);
      inReq <= 1'b0;
      waitForInAck(1'b0);
    end
  endtask

  // Sink side with a random ack delay for back-pressure
  task automatic collectResults();
    int delay;
    for (int i = 0; i < names.size(); i++) begin
      waitForOutReq(1'b1);
      checkResult(names[i], expVals[i], outResult);
      resultCount++;
      delay = $urandom % (MaxAckDelay + 1);
      repeat (delay) @(posedge clk);
      outAck <= 1'b1;
      waitForOutReq(1'b0);
      outAck <= 1'b0;
    end
    // Nothing more may come out
    repeat (DrainCycles) begin
      @(posedge clk);
      if (outReq === 1'b1) begin
        protocolErrors++;
        $display("Extra result %h presented after the last vector", outResult);
      end
    end
  endtask

  // Handshake rules
  always @(posedge clk) begin
    if (!rstN && outReq === 1'b1) begin
      protocolErrors++;
      $display("outReq went high while reset was still asserted");
    end
    if (rstN && !firstReqSent && (inAck === 1'b1 || outReq === 1'b1)) begin
      protocolErrors++;
      $display("inAck or outReq went high before the first request");
    end
    if (inAck === 1'b1 && !prevInAck && !prevInReq) begin
      protocolErrors++;
      $display("inAck rose although inReq was low");
    end
    if (inAck === 1'b0 && prevInAck && prevInReq) begin
      protocolErrors++;
      $display("inAck fell while inReq was still high");
    end
    if (outReq === 1'b1 && !prevOutReq && prevOutAck) begin
      protocolErrors++;
      $display("outReq rose before outAck had dropped");
    end
    if (outReq === 1'b1 && prevOutReq && outResult !== prevResult) begin
      protocolErrors++;
      $display("outResult changed while outReq was high");
    end
    if (outReq === 1'b0 && prevOutReq && !prevOutAck) begin
      protocolErrors++;
      $display("outReq fell without outAck");
    end
    prevInReq  <= inReq;
    prevInAck  <= (inAck === 1'b1);
    prevOutReq <= (outReq === 1'b1);
    prevOutAck <= outAck;
    prevResult <= outResult;
  end

  // Watchdog
  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, %0d of %0d results received", cycleCount,
               resultCount, names.size());
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    int unsigned seedValue;
    int unsigned firstDraw;
    seedValue      = 70445;
    firstDraw      = $urandom(seedValue);
    rstN           = 1'b0;
    inReq          = 1'b0;
    inOp           = OpAdd;
    inA            = '0;
    inB            = '0;
    outAck         = 1'b0;
    valueErrors    = 0;
    protocolErrors = 0;
    stimErrors     = 0;
    resultCount    = 0;
    cycleCount     = 0;
    firstReqSent   = 1'b0;
    prevInReq      = 1'b0;
    prevInAck      = 1'b0;
    prevOutReq     = 1'b0;
    prevOutAck     = 1'b0;
    prevResult     = '0;
    loadVectors();
    cycleLimit = CyclesPerVector * names.size() + CycleMargin;
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    fork
      driveInputs();
      collectResults();
    join
    $display("Results %0d of %0d, value errors %0d, protocol errors %0d, stimulus errors %0d",
             resultCount, names.size(), valueErrors, protocolErrors, stimErrors);
    if (valueErrors == 0 && protocolErrors == 0 && stimErrors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule
